/* source/mips_pkg.sv */
package mips_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  localparam logic [5:0] OP_SPECIAL = 6'h00;
  localparam logic [5:0] OP_REGIMM  = 6'h01;
  localparam logic [5:0] OP_J       = 6'h02;
  localparam logic [5:0] OP_JAL     = 6'h03;
  localparam logic [5:0] OP_BEQ     = 6'h04;
  localparam logic [5:0] OP_BNE     = 6'h05;
  localparam logic [5:0] OP_BLEZ    = 6'h06;
  localparam logic [5:0] OP_BGTZ    = 6'h07;
  localparam logic [5:0] OP_ADDI    = 6'h08;
  localparam logic [5:0] OP_ADDIU   = 6'h09;
  localparam logic [5:0] OP_ANDI    = 6'h0c;
  localparam logic [5:0] OP_ORI     = 6'h0d;
  localparam logic [5:0] OP_LUI     = 6'h0f;
  localparam logic [5:0] OP_LW      = 6'h23;
  localparam logic [5:0] OP_SW      = 6'h2b;

  localparam logic [5:0] FN_SLL     = 6'h00;
  localparam logic [5:0] FN_SRA     = 6'h03;
  localparam logic [5:0] FN_JR      = 6'h08;
  localparam logic [5:0] FN_SYSCALL = 6'h0c;
  localparam logic [5:0] FN_MFHI    = 6'h10;
  localparam logic [5:0] FN_MFLO    = 6'h12;
  localparam logic [5:0] FN_MULT    = 6'h18;
  localparam logic [5:0] FN_DIV     = 6'h1a;
  localparam logic [5:0] FN_ADD     = 6'h20;
  localparam logic [5:0] FN_ADDU    = 6'h21;
  localparam logic [5:0] FN_SUB     = 6'h22;
  localparam logic [5:0] FN_SUBU    = 6'h23;
  localparam logic [5:0] FN_AND     = 6'h24;
  localparam logic [5:0] FN_OR      = 6'h25;
  localparam logic [5:0] FN_SLT     = 6'h2a;

  // rt field under REGIMM
  localparam reg_idx_t RT_BLTZ = 5'd0;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL,
    ALU_SRA, ALU_LUI, ALU_MULT, ALU_DIV, ALU_MFHI, ALU_MFLO
  } alu_op_e;

  typedef enum logic [2:0] {
    BCU_NONE, BCU_EQ, BCU_NE, BCU_LEZ, BCU_GTZ, BCU_LTZ
  } bcu_op_e;

  typedef enum logic [1:0] {JUMP_NONE, JUMP_TARGET, JUMP_REG} jump_e;

  // one word, three field layouts
  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      reg_idx_t   rs;
      reg_idx_t   rt;
      reg_idx_t   rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } r;
    struct packed {
      logic [5:0]  opcode;
      reg_idx_t    rs;
      reg_idx_t    rt;
      logic [15:0] imm;
    } i;
    struct packed {
      logic [5:0]  opcode;
      logic [25:0] index;
    } j;
  } instr_t;

  localparam int       NUM_REGS = 32;
  localparam reg_idx_t REG_RA   = 5'd31;

  localparam int DMEM_WORDS = 64;
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);

  localparam int RETIRE_CREDIT_MAX = 4;
  localparam int RETIRE_CREDIT_W   = $clog2(RETIRE_CREDIT_MAX + 1);

  // sequencer states
  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_EXEC   = 2'd1;
  localparam logic [1:0] ST_RETIRE = 2'd2;

endpackage

/* source/ctrl_if.sv */
`timescale 1ns/1ps

interface ctrl_if
  import mips_pkg::*;
();

  alu_op_e alu_op;
  logic    alu_src;
  bcu_op_e bcu_op;
  jump_e   jump;
  logic    jal;
  logic    reg_write;
  logic    reg_dst;
  logic    mem_to_reg;
  logic    mem_write;
  logic    load_upper;
  logic    syscall;
  logic    illegal;
  // high only in the execute cycle
  logic    exec_en;

  modport decoder (
    output alu_op, alu_src, bcu_op, jump, jal, reg_write, reg_dst,
    output mem_to_reg, mem_write, load_upper, syscall, illegal, exec_en
  );

  modport consumer (
    input alu_op, alu_src, bcu_op, jump, jal, reg_write, reg_dst,
    input mem_to_reg, mem_write, load_upper, syscall, illegal, exec_en
  );

endinterface

/* source/control_unit.sv */
`timescale 1ns/1ps

module control_unit
  import mips_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  input  logic   instr_valid,
  input  instr_t instr_word,
  input  logic   retire_credit,
  output logic   instr_credit,
  output logic   retire_valid,
  output logic   commit,
  ctrl_if.decoder ctrl
);

  logic [1:0]                 state;
  logic [1:0]                 boot_cnt;
  logic [RETIRE_CREDIT_W-1:0] credits;

  // decode of the held word
  always_comb begin
    ctrl.alu_op     = ALU_ADD;
    ctrl.alu_src    = 1'b0;
    ctrl.bcu_op     = BCU_NONE;
    ctrl.jump       = JUMP_NONE;
    ctrl.jal        = 1'b0;
    ctrl.reg_write  = 1'b0;
    ctrl.reg_dst    = 1'b0;
    ctrl.mem_to_reg = 1'b0;
    ctrl.mem_write  = 1'b0;
    ctrl.load_upper = 1'b0;
    ctrl.syscall    = 1'b0;
    ctrl.illegal    = 1'b0;
    case (instr_word.r.opcode)
      OP_SPECIAL: begin
        ctrl.reg_dst = 1'b1;
        case (instr_word.r.funct)
          FN_ADD, FN_ADDU: ctrl.alu_op = ALU_ADD;
          FN_SUB, FN_SUBU: ctrl.alu_op = ALU_SUB;
          FN_AND:          ctrl.alu_op = ALU_AND;
          FN_OR:           ctrl.alu_op = ALU_OR;
          FN_SLT:          ctrl.alu_op = ALU_SLT;
          FN_SLL:          ctrl.alu_op = ALU_SLL;
          FN_SRA:          ctrl.alu_op = ALU_SRA;
          FN_MULT:         ctrl.alu_op = ALU_MULT;
          FN_DIV:          ctrl.alu_op = ALU_DIV;
          FN_MFHI:         ctrl.alu_op = ALU_MFHI;
          FN_MFLO:         ctrl.alu_op = ALU_MFLO;
          FN_JR:           ctrl.jump = JUMP_REG;
          FN_SYSCALL:      ctrl.syscall = 1'b1;
          default:         ctrl.illegal = 1'b1;
        endcase
        // mult, div, jr and syscall leave the GPRs alone
        ctrl.reg_write = !ctrl.syscall && !ctrl.illegal && (ctrl.jump == JUMP_NONE)
                         && (ctrl.alu_op != ALU_MULT) && (ctrl.alu_op != ALU_DIV);
      end
      OP_REGIMM: begin
        if (instr_word.i.rt == RT_BLTZ) ctrl.bcu_op = BCU_LTZ;
        else ctrl.illegal = 1'b1;
      end
      OP_J: ctrl.jump = JUMP_TARGET;
      OP_JAL: begin
        ctrl.jump      = JUMP_TARGET;
        ctrl.jal       = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      OP_BEQ:  ctrl.bcu_op = BCU_EQ;
      OP_BNE:  ctrl.bcu_op = BCU_NE;
      OP_BLEZ: ctrl.bcu_op = BCU_LEZ;
      OP_BGTZ: ctrl.bcu_op = BCU_GTZ;
      OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI, OP_LW: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        if (instr_word.r.opcode == OP_ANDI) ctrl.alu_op = ALU_AND;
        if (instr_word.r.opcode == OP_ORI) ctrl.alu_op = ALU_OR;
        if (instr_word.r.opcode == OP_LUI) begin
          ctrl.alu_op     = ALU_LUI;
          ctrl.load_upper = 1'b1;
        end
        ctrl.mem_to_reg = (instr_word.r.opcode == OP_LW);
      end
      OP_SW: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

  assign retire_valid = (state == ST_RETIRE) && (credits != '0);
  assign commit       = retire_valid;
  // boot pulse plus one per retired instruction
  assign instr_credit = (boot_cnt == 2'd1) || retire_valid;
  assign ctrl.exec_en = (state == ST_EXEC);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ST_IDLE;
      boot_cnt <= 2'd0;
      credits  <= '0;
    end else begin
      if (boot_cnt != 2'd2) boot_cnt <= boot_cnt + 2'd1;

      if (retire_credit && !retire_valid &&
          credits != RETIRE_CREDIT_W'(RETIRE_CREDIT_MAX)) begin
        credits <= credits + 1'b1;
      end else if (!retire_credit && retire_valid) begin
        credits <= credits - 1'b1;
      end

      case (state)
        ST_IDLE:   if (instr_valid) state <= ST_EXEC;
        ST_EXEC:   state <= ST_RETIRE;
        // next word may arrive in the retire cycle itself
        ST_RETIRE: if (retire_valid) state <= instr_valid ? ST_EXEC : ST_IDLE;
        default:   state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file
  import mips_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     accept,
  input  instr_t   word_in,
  input  word_t    pc_in,
  input  logic     commit,
  input  word_t    alu_result,
  input  word_t    mem_data,
  input  word_t    link,
  input  word_t    hi_in,
  input  word_t    lo_in,
  ctrl_if.consumer ctrl,
  output instr_t   instr,
  output word_t    pc,
  output word_t    rs_data,
  output word_t    rt_data,
  output reg_idx_t wr_idx,
  output word_t    wr_data,
  output word_t    hi,
  output word_t    lo
);

  word_t gpr [NUM_REGS];
  word_t rs_read;
  word_t rt_read;
  logic  gpr_we;
  logic  hilo_we;

  assign wr_idx  = ctrl.jal ? REG_RA : (ctrl.reg_dst ? instr.r.rd : instr.r.rt);
  assign wr_data = ctrl.jal ? link : (ctrl.mem_to_reg ? mem_data : alu_result);
  // r0 is never written, so it reads zero
  assign gpr_we  = commit && ctrl.reg_write && (wr_idx != '0);
  assign hilo_we = commit && (ctrl.alu_op == ALU_MULT || ctrl.alu_op == ALU_DIV);

  // accept may coincide with the previous commit
  assign rs_read = (gpr_we && wr_idx == word_in.r.rs) ? wr_data : gpr[word_in.r.rs];
  assign rt_read = (gpr_we && wr_idx == word_in.r.rt) ? wr_data : gpr[word_in.r.rt];

  // accept stage
  always_ff @(posedge clk) begin
    if (accept) begin
      instr   <= word_in;
      pc      <= pc_in;
      rs_data <= rs_read;
      rt_data <= rt_read;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        gpr[i] <= '0;
      end
      hi <= '0;
      lo <= '0;
    end else begin
      if (gpr_we) gpr[wr_idx] <= wr_data;
      if (hilo_we) begin
        hi <= hi_in;
        lo <= lo_in;
      end
    end
  end

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu
  import mips_pkg::*;
(
  input  logic     clk,
  input  word_t    a,
  input  word_t    b,
  input  instr_t   instr,
  input  word_t    hi,
  input  word_t    lo,
  ctrl_if.consumer ctrl,
  output word_t    result,
  output word_t    hi_out,
  output word_t    lo_out
);

  word_t              imm_ext;
  word_t              op_b;
  word_t              res_d;
  word_t              hi_d;
  word_t              lo_d;
  logic signed [63:0] product;

  // andi and ori take a zero-extended immediate
  always_comb begin
    if (ctrl.load_upper) begin
      imm_ext = {instr.i.imm, 16'h0000};
    end else if (ctrl.alu_op == ALU_AND || ctrl.alu_op == ALU_OR) begin
      imm_ext = {16'h0000, instr.i.imm};
    end else begin
      imm_ext = {{16{instr.i.imm[15]}}, instr.i.imm};
    end
  end

  assign op_b    = ctrl.alu_src ? imm_ext : b;
  assign product = $signed(a) * $signed(op_b);

  always_comb begin
    res_d = a + op_b;
    hi_d  = hi;
    lo_d  = lo;
    case (ctrl.alu_op)
      ALU_SUB:  res_d = a - op_b;
      ALU_AND:  res_d = a & op_b;
      ALU_OR:   res_d = a | op_b;
      ALU_SLT:  res_d = {31'b0, $signed(a) < $signed(op_b)};
      ALU_SLL:  res_d = op_b << instr.r.shamt;
      ALU_SRA:  res_d = $signed(op_b) >>> instr.r.shamt;
      ALU_LUI:  res_d = op_b;
      ALU_MULT: {hi_d, lo_d} = product;
      ALU_DIV: begin
        // divide by zero: all-ones quotient, dividend as remainder
        if (op_b == '0) begin
          lo_d = '1;
          hi_d = a;
        end else begin
          lo_d = $signed(a) / $signed(op_b);
          hi_d = $signed(a) % $signed(op_b);
        end
      end
      ALU_MFHI: res_d = hi;
      ALU_MFLO: res_d = lo;
      default:  res_d = a + op_b;
    endcase
  end

  // retire stage
  always_ff @(posedge clk) begin
    if (ctrl.exec_en) begin
      result <= res_d;
      hi_out <= hi_d;
      lo_out <= lo_d;
    end
  end

endmodule

/* source/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit
  import mips_pkg::*;
(
  input  logic     clk,
  input  word_t    pc,
  input  word_t    rs_data,
  input  word_t    rt_data,
  input  instr_t   instr,
  ctrl_if.consumer ctrl,
  output word_t    next_pc,
  output word_t    link
);

  word_t pc_plus4;
  word_t br_target;
  word_t npc_d;
  logic  taken;

  assign pc_plus4  = pc + 32'd4;
  assign br_target = pc_plus4 + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};

  always_comb begin
    case (ctrl.bcu_op)
      BCU_EQ:  taken = (rs_data == rt_data);
      BCU_NE:  taken = (rs_data != rt_data);
      BCU_LEZ: taken = rs_data[31] || (rs_data == '0);
      BCU_GTZ: taken = !rs_data[31] && (rs_data != '0);
      BCU_LTZ: taken = rs_data[31];
      default: taken = 1'b0;
    endcase
  end

  // no delay slot
  always_comb begin
    case (ctrl.jump)
      JUMP_TARGET: npc_d = {pc_plus4[31:28], instr.j.index, 2'b00};
      JUMP_REG:    npc_d = rs_data;
      default:     npc_d = taken ? br_target : pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (ctrl.exec_en) begin
      next_pc <= npc_d;
      link    <= pc_plus4;
    end
  end

endmodule

/* source/data_mem.sv */
`timescale 1ns/1ps

module data_mem
  import mips_pkg::*;
(
  input  logic     clk,
  input  word_t    addr,
  input  word_t    wr_data,
  input  logic     commit,
  ctrl_if.consumer ctrl,
  output word_t    rd_data
);

  word_t              mem [DMEM_WORDS];
  logic [DMEM_AW-1:0] word_idx;

  // word address, upper bits ignored
  assign word_idx = addr[DMEM_AW+1:2];
  assign rd_data  = mem[word_idx];

  initial begin
    for (int i = 0; i < DMEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  always @(posedge clk) begin
    if (commit && ctrl.mem_write) mem[word_idx] <= wr_data;
  end

endmodule

/* source/exec_core.sv */
`timescale 1ns/1ps

module exec_core
  import mips_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     instr_valid,
  input  word_t    instr_word,
  input  word_t    instr_pc,
  output logic     instr_credit,
  output logic     retire_valid,
  output word_t    retire_pc,
  output word_t    retire_next_pc,
  output logic     retire_wr_en,
  output reg_idx_t retire_wr_idx,
  output word_t    retire_wr_data,
  output logic     retire_store,
  output word_t    retire_addr,
  output word_t    retire_store_data,
  output logic     retire_syscall,
  output logic     retire_illegal,
  input  logic     retire_credit
);

  instr_t instr;
  word_t  pc;
  word_t  rs_data;
  word_t  rt_data;
  word_t  hi;
  word_t  lo;
  word_t  alu_result;
  word_t  hi_out;
  word_t  lo_out;
  word_t  link;
  word_t  mem_data;
  logic   commit;

  ctrl_if ctrl ();

  control_unit u_control_unit (
    .clk           (clk),
    .arst_n        (arst_n),
    .instr_valid   (instr_valid),
    .instr_word    (instr),
    .retire_credit (retire_credit),
    .instr_credit  (instr_credit),
    .retire_valid  (retire_valid),
    .commit        (commit),
    .ctrl          (ctrl.decoder)
  );

  reg_file u_reg_file (
    .clk        (clk),
    .arst_n     (arst_n),
    .accept     (instr_valid),
    .word_in    (instr_word),
    .pc_in      (instr_pc),
    .commit     (commit),
    .alu_result (alu_result),
    .mem_data   (mem_data),
    .link       (link),
    .hi_in      (hi_out),
    .lo_in      (lo_out),
    .ctrl       (ctrl.consumer),
    .instr      (instr),
    .pc         (pc),
    .rs_data    (rs_data),
    .rt_data    (rt_data),
    .wr_idx     (retire_wr_idx),
    .wr_data    (retire_wr_data),
    .hi         (hi),
    .lo         (lo)
  );

  alu u_alu (
    .clk    (clk),
    .a      (rs_data),
    .b      (rt_data),
    .instr  (instr),
    .hi     (hi),
    .lo     (lo),
    .ctrl   (ctrl.consumer),
    .result (alu_result),
    .hi_out (hi_out),
    .lo_out (lo_out)
  );

  branch_unit u_branch_unit (
    .clk     (clk),
    .pc      (pc),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .instr   (instr),
    .ctrl    (ctrl.consumer),
    .next_pc (retire_next_pc),
    .link    (link)
  );

  data_mem u_data_mem (
    .clk     (clk),
    .addr    (alu_result),
    .wr_data (rt_data),
    .commit  (commit),
    .ctrl    (ctrl.consumer),
    .rd_data (mem_data)
  );

  assign retire_pc         = pc;
  assign retire_addr       = alu_result;
  assign retire_store_data = rt_data;
  assign retire_wr_en      = ctrl.reg_write;
  assign retire_store      = ctrl.mem_write;
  assign retire_syscall    = ctrl.syscall;
  assign retire_illegal    = ctrl.illegal;

endmodule

/* verification/mips_model.svh */
`ifndef MIPS_MODEL_SVH
`define MIPS_MODEL_SVH

typedef struct {
  word_t    pc;
  word_t    next_pc;
  logic     wr_en;
  reg_idx_t wr_idx;
  word_t    wr_data;
  logic     store;
  word_t    addr;
  word_t    store_data;
  logic     syscall;
  logic     illegal;
} retire_rec_t;

word_t m_gpr [32];
word_t m_hi;
word_t m_lo;
word_t m_mem [DMEM_WORDS];

function automatic void reset_model();
  for (int i = 0; i < 32; i++) begin
    m_gpr[i] = '0;
  end
  for (int i = 0; i < DMEM_WORDS; i++) begin
    m_mem[i] = '0;
  end
  m_hi = '0;
  m_lo = '0;
endfunction

// expected record of one instruction, state updated in program order
function automatic retire_rec_t predict_retire(input word_t w, input word_t pc);
  retire_rec_t r;
  logic [5:0]  op;
  logic [5:0]  fn;
  reg_idx_t    rs;
  reg_idx_t    rt;
  reg_idx_t    rd;
  logic [4:0]  sh;
  word_t       a;
  word_t       b;
  word_t       se;
  word_t       pc4;
  word_t       br;
  longint      prod;
  op  = w[31:26];
  rs  = w[25:21];
  rt  = w[20:16];
  rd  = w[15:11];
  sh  = w[10:6];
  fn  = w[5:0];
  a   = m_gpr[rs];
  b   = m_gpr[rt];
  se  = {{16{w[15]}}, w[15:0]};
  pc4 = pc + 32'd4;
  br  = pc4 + {se[29:0], 2'b00};
  r.pc         = pc;
  r.next_pc    = pc4;
  r.wr_en      = 1'b0;
  r.wr_idx     = rt;
  r.wr_data    = '0;
  r.store      = 1'b0;
  r.addr       = '0;
  r.store_data = '0;
  r.syscall    = 1'b0;
  r.illegal    = 1'b0;
  case (op)
    OP_SPECIAL: begin
      r.wr_en  = 1'b1;
      r.wr_idx = rd;
      case (fn)
        FN_ADD, FN_ADDU: r.wr_data = a + b;
        FN_SUB, FN_SUBU: r.wr_data = a - b;
        FN_AND:  r.wr_data = a & b;
        FN_OR:   r.wr_data = a | b;
        FN_SLT:  r.wr_data = (int'(a) < int'(b)) ? 32'd1 : 32'd0;
        FN_SLL:  r.wr_data = b << sh;
        FN_SRA:  r.wr_data = word_t'(int'(b) >>> sh);
        FN_MFHI: r.wr_data = m_hi;
        FN_MFLO: r.wr_data = m_lo;
        FN_MULT: begin
          r.wr_en = 1'b0;
          prod    = longint'(int'(a)) * longint'(int'(b));
          m_hi    = prod[63:32];
          m_lo    = prod[31:0];
        end
        FN_DIV: begin
          r.wr_en = 1'b0;
          if (b == '0) begin
            m_lo = '1;
            m_hi = a;
          end else begin
            m_lo = word_t'(longint'(int'(a)) / longint'(int'(b)));
            m_hi = word_t'(longint'(int'(a)) % longint'(int'(b)));
          end
        end
        FN_JR: begin
          r.wr_en   = 1'b0;
          r.next_pc = a;
        end
        FN_SYSCALL: begin
          r.wr_en   = 1'b0;
          r.syscall = 1'b1;
        end
        default: begin
          r.wr_en   = 1'b0;
          r.illegal = 1'b1;
        end
      endcase
    end
    OP_ADDI, OP_ADDIU: begin
      r.wr_en   = 1'b1;
      r.wr_data = a + se;
    end
    OP_ANDI: begin
      r.wr_en   = 1'b1;
      r.wr_data = a & {16'h0000, w[15:0]};
    end
    OP_ORI: begin
      r.wr_en   = 1'b1;
      r.wr_data = a | {16'h0000, w[15:0]};
    end
    OP_LUI: begin
      r.wr_en   = 1'b1;
      r.wr_data = {w[15:0], 16'h0000};
    end
    OP_LW: begin
      r.wr_en   = 1'b1;
      r.addr    = a + se;
      r.wr_data = m_mem[r.addr[7:2]];
    end
    OP_SW: begin
      r.store      = 1'b1;
      r.addr       = a + se;
      r.store_data = b;
      m_mem[r.addr[7:2]] = b;
    end
    OP_J:    r.next_pc = {pc4[31:28], w[25:0], 2'b00};
    OP_JAL: begin
      r.next_pc = {pc4[31:28], w[25:0], 2'b00};
      r.wr_en   = 1'b1;
      r.wr_idx  = 5'd31;
      r.wr_data = pc4;
    end
    OP_BEQ:  r.next_pc = (a == b) ? br : pc4;
    OP_BNE:  r.next_pc = (a != b) ? br : pc4;
    OP_BLEZ: r.next_pc = (int'(a) <= 0) ? br : pc4;
    OP_BGTZ: r.next_pc = (int'(a) > 0) ? br : pc4;
    OP_REGIMM: begin
      if (rt == RT_BLTZ) r.next_pc = (int'(a) < 0) ? br : pc4;
      else r.illegal = 1'b1;
    end
    default: r.illegal = 1'b1;
  endcase
  // r0 stays zero
  if (r.wr_en && r.wr_idx != 5'd0) m_gpr[r.wr_idx] = r.wr_data;
  return r;
endfunction

`endif

/* verification/exec_core_tb.sv */
`timescale 1ns/1ps

module exec_core_tb
  import mips_pkg::*;
();

  localparam int N_INSTR      = 400;
  localparam int WAIT_LIMIT   = 200;
  localparam int RESET_CYCLES = 3;

  localparam logic [5:0] R_FUNCTS [15] = '{
    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_SLT, FN_SLL,
    FN_SRA, FN_MULT, FN_DIV, FN_MFHI, FN_MFLO, FN_JR, FN_SYSCALL
  };

  logic     clk;
  logic     arst_n;
  logic     instr_valid;
  word_t    instr_word;
  word_t    instr_pc;
  logic     instr_credit;
  logic     retire_valid;
  word_t    retire_pc;
  word_t    retire_next_pc;
  logic     retire_wr_en;
  reg_idx_t retire_wr_idx;
  word_t    retire_wr_data;
  logic     retire_store;
  word_t    retire_addr;
  word_t    retire_store_data;
  logic     retire_syscall;
  logic     retire_illegal;
  logic     retire_credit;

  `include "mips_model.svh"

  retire_rec_t expected;
  logic        pending;
  int          cycle;
  int          acc_cycle;
  int          in_credits;
  int          rc_held;
  int          starve;
  word_t       cur_pc;

  exec_core dut_i (
    .clk               (clk),
    .arst_n            (arst_n),
    .instr_valid       (instr_valid),
    .instr_word        (instr_word),
    .instr_pc          (instr_pc),
    .instr_credit      (instr_credit),
    .retire_valid      (retire_valid),
    .retire_pc         (retire_pc),
    .retire_next_pc    (retire_next_pc),
    .retire_wr_en      (retire_wr_en),
    .retire_wr_idx     (retire_wr_idx),
    .retire_wr_data    (retire_wr_data),
    .retire_store      (retire_store),
    .retire_addr       (retire_addr),
    .retire_store_data (retire_store_data),
    .retire_syscall    (retire_syscall),
    .retire_illegal    (retire_illegal),
    .retire_credit     (retire_credit)
  );

  always #5 clk = ~clk;

  task automatic end_with_failure();
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_error(input string msg);
    $display("%s (time %0d ns)", msg, $time);
    end_with_failure();
  endtask

  task automatic check_word(input string field, input word_t got, input word_t want);
    if (got !== want) begin
      $display("[FAIL] %0d ns: %s is %h, expected %h", $time, field, got, want);
      end_with_failure();
    end
  endtask

  task automatic check_idx(input string field, input reg_idx_t got, input reg_idx_t want);
    if (got !== want) begin
      $display("[FAIL] %0d ns: %s is %0d, expected %0d", $time, field, got, want);
      end_with_failure();
    end
  endtask

  task automatic check_record(input retire_rec_t e);
    check_word("retire_pc", retire_pc, e.pc);
    check_word("retire_next_pc", retire_next_pc, e.next_pc);
    // wr_en, store, syscall, illegal
    check_word("retire_flags",
               {28'd0, retire_wr_en, retire_store, retire_syscall, retire_illegal},
               {28'd0, e.wr_en, e.store, e.syscall, e.illegal});
    if (e.wr_en) begin
      check_idx("retire_wr_idx", retire_wr_idx, e.wr_idx);
      check_word("retire_wr_data", retire_wr_data, e.wr_data);
    end
    if (e.store) begin
      check_word("retire_addr", retire_addr, e.addr);
      check_word("retire_store_data", retire_store_data, e.store_data);
    end
  endtask

  // one falling edge: sample, check the handshake, grant retire credits
  task automatic next_cycle();
    logic rv;
    logic want_rv;
    logic grant;
    @(negedge clk);
    cycle++;
    instr_valid = 1'b0;
    rv      = retire_valid;
    want_rv = pending && (cycle >= acc_cycle + 2) && (rc_held > 0);
    if (rv !== want_rv) begin
      if (rv === 1'b1) report_error("retire_valid high with no record due or no credit held");
      else report_error("retire_valid low although a record was due and a credit was held");
    end
    if (rv) begin
      check_record(expected);
      pending = 1'b0;
    end
    if (instr_credit !== ((cycle == 1) || want_rv)) begin
      report_error("instr_credit pulse in the wrong cycle");
    end
    if (instr_credit) in_credits++;
    // no grants inside a starve window
    if (starve > 0) begin
      grant = 1'b0;
      starve--;
    end else begin
      grant = (($urandom % 3) == 0);
    end
    retire_credit = grant;
    if (grant && !want_rv && rc_held < RETIRE_CREDIT_MAX) rc_held++;
    else if (!grant && want_rv) rc_held--;
  endtask

  task automatic wait_instr_credit();
    int waited;
    waited = 0;
    while (in_credits == 0) begin
      if (waited == WAIT_LIMIT) report_error("timed out waiting for instr_credit");
      next_cycle();
      waited++;
    end
  endtask

  task automatic wait_last_retire();
    int waited;
    waited = 0;
    while (pending) begin
      if (waited == WAIT_LIMIT) report_error("timed out waiting for the last retire_valid");
      next_cycle();
      waited++;
    end
  endtask

  task automatic send_instr(input word_t w);
    expected    = predict_retire(w, cur_pc);
    instr_word  = w;
    instr_pc    = cur_pc;
    instr_valid = 1'b1;
    acc_cycle   = cycle;
    pending     = 1'b1;
    in_credits--;
    cur_pc = expected.next_pc;
  endtask

  function automatic word_t random_instr();
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    logic [15:0] imm;
    logic [5:0]  fn;
    word_t       w;
    rs  = 5'($urandom % 8);
    rt  = 5'($urandom % 8);
    rd  = 5'($urandom % 8);
    imm = 16'($urandom);
    case ($urandom % 20)
      0:  w = {OP_ADDI, rs, rt, imm};
      1:  w = {OP_ADDIU, rs, rt, imm};
      2:  w = {OP_ANDI, rs, rt, imm};
      3:  w = {OP_ORI, rs, rt, imm};
      4:  w = {OP_LUI, 5'd0, rt, imm};
      // a handful of word addresses off r0
      5:  w = {OP_LW, 5'd0, rt, 16'(($urandom % 8) * 4)};
      6:  w = {OP_SW, 5'd0, rt, 16'(($urandom % 8) * 4)};
      7:  w = {(($urandom % 2) == 0) ? OP_J : OP_JAL, 26'($urandom)};
      8:  w = {OP_BEQ, rs, rt, imm};
      9:  w = {OP_BNE, rs, rt, imm};
      10: w = {OP_BLEZ, rs, 5'd0, imm};
      11: w = {OP_BGTZ, rs, 5'd0, imm};
      12: w = {OP_REGIMM, rs, RT_BLTZ, imm};
      default: begin
        fn = R_FUNCTS[$urandom % 15];
        if (fn == FN_JR && ($urandom % 4) == 0) rs = REG_RA;
        // skip the one signed divide that overflows
        if (fn == FN_DIV && m_gpr[rs] == 32'h8000_0000 && m_gpr[rt] == '1) fn = FN_MULT;
        w = {OP_SPECIAL, rs, rt, rd, 5'($urandom), fn};
      end
    endcase
    return w;
  endfunction

  function automatic word_t illegal_instr();
    case ($urandom % 3)
      0:       return {6'h3f, 26'($urandom)};
      1:       return {OP_SPECIAL, 20'($urandom), 6'h01};
      default: return {OP_REGIMM, 5'($urandom), 5'd1, 16'($urandom)};
    endcase
  endfunction

  initial begin
    int unsigned seed_draw;
    word_t       w;
    seed_draw     = $urandom(2);
    clk           = 1'b0;
    arst_n        = 1'b0;
    instr_valid   = 1'b0;
    instr_word    = '0;
    instr_pc      = '0;
    retire_credit = 1'b0;
    pending       = 1'b0;
    cycle         = 0;
    acc_cycle     = 0;
    in_credits    = 0;
    rc_held       = 0;
    starve        = 0;
    cur_pc        = 32'h0040_0000;
    reset_model();
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    if (instr_credit !== 1'b0 || retire_valid !== 1'b0) begin
      report_error("instr_credit or retire_valid high right after reset");
    end
    for (int n = 0; n < N_INSTR; n++) begin
      wait_instr_credit();
      repeat ($urandom % 3) next_cycle();
      // hold back retire credits now and then
      if (n % 50 == 25) starve = 30;
      w = (($urandom % 16) == 0) ? illegal_instr() : random_instr();
      send_instr(w);
    end
    wait_last_retire();
    $display("Test passed");
    $finish;
  end

endmodule

/* list.f */
+incdir+verification
source/mips_pkg.sv
source/ctrl_if.sv
source/control_unit.sv
source/reg_file.sv
source/alu.sv
source/branch_unit.sv
source/data_mem.sv
source/exec_core.sv
verification/exec_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= exec_core_tb
RTL_TOP   ?= exec_core
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Test passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
